// File: common/aluPkg.sv
// Datapath types: word and flag vectors, flag positions, ALU operation codes, step and result
package aluPkg;

    typedef logic [15:0] wordT;
    typedef logic [4:0]  ccrT;     // X N Z V C

    // Flag positions inside ccrT
    localparam int flagC = 0;
    localparam int flagV = 1;
    localparam int flagZ = 2;
    localparam int flagN = 3;
    localparam int flagX = 4;

    // Bit 4 marks a shift, bit 3 the adder, bit 0 subtract or shift right
    typedef enum logic [4:0] {
        opNop  = 5'd0,
        opOr   = 5'd4,
        opEor  = 5'd5,
        opAnd  = 5'd6,
        opExt  = 5'd7,
        opSub0 = 5'd9,    // NOT as 0 - op - 1
        opAdd  = 5'd10,
        opSub  = 5'd11,
        opAddc = 5'd12,
        opSubc = 5'd13,
        opAddx = 5'd14,
        opSubx = 5'd15,
        opAsl  = 5'd16,
        opAsr  = 5'd17,
        opLsl  = 5'd18,
        opLsr  = 5'd19,
        opRol  = 5'd20,
        opRor  = 5'd21,
        opRoxl = 5'd22,
        opRoxr = 5'd23
    } aluOpT;

    // One ALU step as handed over by the sequencer
    typedef struct packed {
        logic [2:0] column;   // Microcode column 1-4
        wordT       aOperand; // Destination
        wordT       dOperand; // Source
        logic       isByte;
        logic       finish;   // Last ALU step of the instruction
    } stepT;

    typedef struct packed {
        wordT result;
        ccrT  flags;
    } execT;

endpackage

// File: common/decodePkg.sv
// Instruction decode types: opcode, row and column vectors, CCR mask constants, decoded struct
package decodePkg;

    typedef logic [15:0] irdT;
    typedef logic [15:0] rowT;     // One-hot, bit 0 means no ALU operation
    typedef logic [2:0]  columnT;

    // Flag update masks, bit order X N Z V C
    localparam aluPkg::ccrT KNZ00   = 5'b01111;  // Operators clear V and C themselves
    localparam aluPkg::ccrT KKZKK   = 5'b00100;
    localparam aluPkg::ccrT KNZVC   = 5'b01111;
    localparam aluPkg::ccrT CUPDALL = 5'b11111;
    localparam aluPkg::ccrT NOMASK  = 5'b00000;

    typedef struct packed {
        rowT  row;
        logic isArX;    // ADDX, SUBX, NEGX only clear Z
        logic noCcrEn;  // ADDA, SUBA, ADDQ/SUBQ to An, MOVEA
    } decodeT;

endpackage

// File: execute/aluShifter.sv
// One-bit word or byte shifter with carry insertion
`timescale 1ns/1ps

module aluShifter (
    input  aluPkg::wordT operand,
    input  logic         isByte,
    input  logic         shiftRight,
    input  logic         carryIn,
    output aluPkg::wordT shifted
);
    import aluPkg::*;

    wordT sized;

    // Byte right shift takes the carry into bit 7 via bit 8
    always_comb begin
        sized = operand;
        if (isByte & shiftRight) begin
            sized[8] = carryIn;
        end
    end

    always_comb begin
        if (shiftRight) begin
            shifted = {carryIn, sized[15:1]};
        end else begin
            shifted = {sized[14:0], carryIn};   // Carry enters at bit 0
        end
    end

endmodule

// File: execute/aluExecute.sv
// ALU execute stage: adder, logic unit, shifter and new flag computation
`timescale 1ns/1ps

module aluExecute (
    input  aluPkg::stepT   step,
    input  decodePkg::rowT row,
    input  aluPkg::aluOpT  aluOp,
    input  aluPkg::ccrT    ccrIn,
    output aluPkg::execT   exec
);
    import aluPkg::*;

    logic [16:0] sum;
    logic        addCin, isSub, cout, ovf;
    logic        srcMsb, dstMsb, sumMsb;
    logic        msb, nextMsb, shiftCin;
    wordT        addResult, shifted, aluResult;
    ccrT         newFlags;

    assign isSub   = aluOp[0];
    assign msb     = step.isByte ? step.aOperand[7] : step.aOperand[15];
    assign nextMsb = step.isByte ? step.aOperand[6] : step.aOperand[14];

    always_comb begin
        case (aluOp)
            opSub0:         addCin = 1'b1;
            opAddc, opSubc: addCin = ccrIn[flagC];
            opAddx, opSubx: addCin = ccrIn[flagX];
            default:        addCin = 1'b0;
        endcase
    end

    // Source plus or minus destination plus or minus carry
    always_comb begin
        if (step.isByte) begin
            sum = isSub ? {9'b0, step.dOperand[7:0]} - {9'b0, step.aOperand[7:0]} - 17'(addCin)
                        : {9'b0, step.dOperand[7:0]} + {9'b0, step.aOperand[7:0]} + 17'(addCin);
            cout      = sum[8];
            addResult = {{8{sum[7]}}, sum[7:0]};
        end else begin
            sum = isSub ? {1'b0, step.dOperand} - {1'b0, step.aOperand} - 17'(addCin)
                        : {1'b0, step.dOperand} + {1'b0, step.aOperand} + 17'(addCin);
            cout      = sum[16];
            addResult = sum[15:0];
        end
        sumMsb = step.isByte ? sum[7] : sum[15];
        dstMsb = step.isByte ? step.dOperand[7] : step.dOperand[15];
        srcMsb = isSub ? ~msb : msb;
        ovf    = (srcMsb & dstMsb & ~sumMsb) | (~srcMsb & ~dstMsb & sumMsb);
    end

    always_comb begin
        case (aluOp)
            opAsr, opRol:   shiftCin = msb;
            opRor:          shiftCin = step.aOperand[0];
            opRoxl, opRoxr: shiftCin = ccrIn[flagX];
            default:        shiftCin = 1'b0;   // LSL, LSR, ASL
        endcase
    end

    aluShifter uShifter (
        .operand    (step.aOperand),
        .isByte     (step.isByte),
        .shiftRight (aluOp[0]),
        .carryIn    (shiftCin),
        .shifted    (shifted)
    );

    always_comb begin
        case (aluOp)
            opOr:    aluResult = step.aOperand | step.dOperand;
            opEor:   aluResult = step.aOperand ^ step.dOperand;
            opAnd:   aluResult = step.aOperand & step.dOperand;
            opExt:   aluResult = {{8{step.aOperand[7]}}, step.aOperand[7:0]};
            opNop:   aluResult = step.aOperand;
            default: aluResult = aluOp[4] ? shifted : addResult;
        endcase
    end

    always_comb begin
        newFlags        = '0;
        newFlags[flagX] = ccrIn[flagX];
        newFlags[flagN] = step.isByte ? aluResult[7] : aluResult[15];
        newFlags[flagZ] = step.isByte ? ~(|aluResult[7:0]) : ~(|aluResult);
        case (aluOp)
            // Zero ROXL/ROXR count still reports X in C
            opAnd: newFlags[flagC] = (step.column == 3'd1) & (row[8] | row[11]) & ccrIn[flagX];
            opAdd, opAddc, opAddx, opSub, opSubc, opSubx: begin
                newFlags[flagC] = cout;
                newFlags[flagX] = cout;
                newFlags[flagV] = ovf;
            end
            opLsl, opRoxl: begin
                newFlags[flagC] = msb;
                newFlags[flagX] = msb;
            end
            opLsr, opRoxr, opAsr: begin
                newFlags[flagC] = step.aOperand[0];
                newFlags[flagX] = step.aOperand[0];
            end
            opAsl: begin
                newFlags[flagC] = msb;
                newFlags[flagX] = msb;
                newFlags[flagV] = ccrIn[flagV] | (msb ^ nextMsb);  // Any sign change so far
            end
            opRol:   newFlags[flagC] = msb;
            opRor:   newFlags[flagC] = step.aOperand[0];
            default: newFlags[flagC] = 1'b0;   // OR, EOR, EXT, NOT clear C and V
        endcase
    end

    assign exec = '{result: aluResult, flags: newFlags};

endmodule

// File: decode/irdRowDecoder.sv
// Opcode to ALU row decoder with registered row, sticky-Z and no-flags bits
`timescale 1ns/1ps

module irdRowDecoder (
    input  logic              clk,
    input  logic              arstN,
    input  logic              irdValid,
    input  decodePkg::irdT    ird,
    output decodePkg::decodeT decoded
);
    import decodePkg::*;

    logic       eaRdir;     // Data or address register direct
    logic       eaAdir;     // Address register direct
    logic       size11;
    logic [1:0] shiftType;
    rowT        nextRow;
    logic       nextArX;
    logic       nextNoCcr;

    function automatic rowT rowOf(input int unsigned n);
        rowOf = rowT'(1) << n;
    endfunction

    assign eaRdir    = (ird[5:4] == 2'b00);
    assign eaAdir    = (ird[5:3] == 3'b001);
    assign size11    = ird[7] & ird[6];
    assign shiftType = size11 ? ird[10:9] : ird[4:3];  // Memory or register shift

    always_comb begin
        case (ird[15:12])
            4'h0: begin
                if (ird[8]) begin
                    nextRow = ird[7] ? rowOf(14) : rowOf(13);   // Dynamic bit ops
                end else begin
                    case (ird[11:9])
                        3'b000:  nextRow = rowOf(14);           // ORI
                        3'b001:  nextRow = rowOf(4);            // ANDI
                        3'b010:  nextRow = rowOf(5);            // SUBI
                        3'b011:  nextRow = rowOf(2);            // ADDI
                        3'b100:  nextRow = ird[7] ? rowOf(14) : rowOf(13);
                        3'b101:  nextRow = rowOf(13);           // EORI
                        3'b110:  nextRow = rowOf(6);            // CMPI
                        default: nextRow = rowOf(0);
                    endcase
                end
            end
            4'h1, 4'h2, 4'h3, 4'h7: nextRow = rowOf(2);     // MOVE, MOVEQ
            4'h4: begin
                if (ird[8]) begin
                    nextRow = rowOf(6);                         // CHK
                end else begin
                    case (ird[11:9])
                        3'b000:  nextRow = rowOf(10);           // NEGX
                        3'b001:  nextRow = rowOf(4);            // CLR
                        3'b010:  nextRow = rowOf(5);            // NEG
                        3'b011:  nextRow = rowOf(11);           // NOT
                        3'b100:  nextRow = ird[7] ? rowOf(8) : rowOf(0);  // EXT, NBCD gone
                        3'b101:  nextRow = rowOf(15);           // TST, TAS
                        default: nextRow = rowOf(0);
                    endcase
                end
            end
            4'h5:    nextRow = size11 ? rowOf(15) : (ird[8] ? rowOf(5) : rowOf(2));
            4'h8:    nextRow = (size11 | (ird[8] & eaRdir)) ? rowOf(0) : rowOf(14);
            4'h9:    nextRow = (ird[8] & ~size11 & eaRdir) ? rowOf(10) : rowOf(5);
            4'hb:    nextRow = (ird[8] & ~size11 & ~eaAdir) ? rowOf(13) : rowOf(6);
            4'hc:    nextRow = (size11 | (ird[8] & eaRdir)) ? rowOf(0) : rowOf(4);
            4'hd:    nextRow = (ird[8] & ~size11 & eaRdir) ? rowOf(12) : rowOf(2);
            4'he: begin
                case ({shiftType, ird[8]})
                    3'd0: nextRow = rowOf(2);    // ASR
                    3'd1: nextRow = rowOf(3);    // ASL
                    3'd2: nextRow = rowOf(5);    // LSR
                    3'd3: nextRow = rowOf(4);    // LSL
                    3'd4: nextRow = rowOf(8);    // ROXR
                    3'd5: nextRow = rowOf(11);   // ROXL
                    3'd6: nextRow = rowOf(10);   // ROR
                    default: nextRow = rowOf(9); // ROL
                endcase
            end
            default: nextRow = rowOf(0);         // Bcc, line A, line F
        endcase
    end

    // NEGX, SUBX, ADDX share rows 10 and 12 with flag-setting ops of other groups
    assign nextArX = (ird[15:12] inside {4'h4, 4'h9, 4'hd}) & (nextRow[10] | nextRow[12]);

    assign nextNoCcr = (ird[15] & ~ird[13] & ird[12] & size11)
                     | ((ird[15:12] == 4'h5) & eaAdir)
                     | (~ird[15] & ~ird[14] & ird[13] & (ird[8:6] == 3'b001));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decoded <= '{row: rowOf(0), isArX: 1'b0, noCcrEn: 1'b0};
        end else if (irdValid) begin
            decoded <= '{row: nextRow, isArX: nextArX, noCcrEn: nextNoCcr};
        end
    end

    // Flag-free instructions only decode to the add, subtract and DBcc rows
    noCcrRow: assert property (@(posedge clk) disable iff (!arstN)
        decoded.noCcrEn |-> (decoded.row[2] | decoded.row[5] | decoded.row[15]));

endmodule

// File: decode/aluOpSelect.sv
// Row by column lookup of the ALU operation and the CCR update mask
`timescale 1ns/1ps

module aluOpSelect (
    input  decodePkg::rowT    row,
    input  decodePkg::columnT column,
    input  logic              finish,
    output aluPkg::aluOpT     aluOp,
    output aluPkg::ccrT       ccrMask
);
    import aluPkg::*;
    import decodePkg::*;

    ccrT maskCol1;

    // Column 1 is the AND step before the main loop
    assign maskCol1 = (finish | row[13] | row[14]) ? KKZKK : KNZ00;

    always_comb begin
        aluOp = opNop;
        if (column == 3'd1) begin
            aluOp = opAnd;
        end else if (column inside {3'd2, 3'd3, 3'd4}) begin
            case (1'b1)
                row[2]:  aluOp = (column == 3'd2) ? opAdd : (column == 3'd3) ? opAddc : opAsr;
                row[3]:  aluOp = (column == 3'd4) ? opAsl : opNop;
                row[4]:  aluOp = (column == 3'd4) ? opLsl : opAnd;
                row[5],
                row[6]:  aluOp = (column == 3'd2) ? opSub : (column == 3'd3) ? opSubc : opLsr;
                row[8]:  aluOp = (column == 3'd2) ? opExt : (column == 3'd3) ? opAnd : opRoxr;
                row[9]:  aluOp = (column == 3'd4) ? opRol : opNop;
                row[10]: aluOp = (column == 3'd2) ? opSubx : (column == 3'd3) ? opSubc : opRor;
                row[11]: aluOp = (column == 3'd4) ? opRoxl : opSub0;
                row[12]: aluOp = opAddx;
                row[13]: aluOp = opEor;
                row[14]: aluOp = (column == 3'd4) ? opEor : opOr;
                row[15]: aluOp = (column == 3'd3) ? opAdd : opOr;  // ADD for DBcc
                default: aluOp = opNop;
            endcase
        end
    end

    always_comb begin
        ccrMask = NOMASK;
        case (column)
            3'd1: ccrMask = maskCol1;
            3'd2, 3'd3: begin
                case (1'b1)
                    row[2], row[5], row[10], row[12]: ccrMask = CUPDALL;
                    row[6], row[11]:                  ccrMask = KNZVC;    // CMP, NOT
                    row[4], row[8], row[13], row[14]: ccrMask = KNZ00;
                    default:                          ccrMask = NOMASK;   // Rows 3, 9, 15
                endcase
            end
            3'd4: begin
                case (1'b1)
                    row[2], row[3], row[4], row[5]: ccrMask = CUPDALL;    // Arithmetic and logic shifts
                    row[8], row[11]:                ccrMask = CUPDALL;    // ROXR, ROXL
                    row[9], row[10]:                ccrMask = KNZ00;      // ROL, ROR keep X
                    default:                        ccrMask = NOMASK;
                endcase
            end
            default: ccrMask = NOMASK;
        endcase
    end

    // Only the BCD leftovers in rows 3 and 9 may select no operation
    always_comb begin
        if (!row[0] && column inside {3'd1, 3'd2, 3'd3, 3'd4}
                && !((row[3] | row[9]) && column inside {3'd2, 3'd3})) begin
            opDefined: assert final (aluOp != opNop);
        end
    end

endmodule

// File: src/ccrUpdate.sv
// Result register and CCR with masked merge, sticky Z and direct load
`timescale 1ns/1ps

module ccrUpdate (
    input  logic              clk,
    input  logic              arstN,
    input  logic              stepValid,
    input  aluPkg::execT      exec,
    input  aluPkg::ccrT       ccrMask,
    input  decodePkg::decodeT decoded,
    input  logic              finish,
    input  logic              ccrLoad,
    input  aluPkg::ccrT       ccrLoadValue,
    output aluPkg::wordT      result,
    output logic              resultValid,
    output aluPkg::ccrT       ccr
);
    import aluPkg::*;

    ccrT merged;

    always_comb begin
        merged = (exec.flags & ccrMask) | (ccr & ~ccrMask);
        // Multi-step and extended ops can only clear Z
        if ((finish | decoded.isArX) & ccrMask[flagZ]) begin
            merged[flagZ] = exec.flags[flagZ] & ccr[flagZ];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result      <= '0;
            resultValid <= 1'b0;
            ccr         <= '0;
        end else begin
            resultValid <= stepValid;
            if (stepValid) begin
                result <= exec.result;
            end
            if (ccrLoad) begin
                ccr <= ccrLoadValue;         // Direct load beats a step
            end else if (stepValid & ~decoded.noCcrEn) begin
                ccr <= merged;
            end
        end
    end

    // A sticky-Z step never sets a cleared Z again
    stickyZHolds: assert property (
        @(posedge clk) disable iff (!arstN)
        stepValid && !ccrLoad && (finish || decoded.isArX) && !ccr[flagZ] |=> !ccr[flagZ]
    );

endmodule

// File: src/aluTop.sv
// ALU slice top level: decoder, operation select, execute and CCR update
`timescale 1ns/1ps

module aluTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic              irdValid,
    input  decodePkg::irdT    ird,
    input  logic              stepValid,
    input  aluPkg::stepT      step,
    input  logic              ccrLoad,
    input  aluPkg::ccrT       ccrLoadValue,
    output aluPkg::wordT      result,
    output logic              resultValid,
    output aluPkg::ccrT       ccr
);
    import aluPkg::*;
    import decodePkg::*;

    decodeT decoded;
    aluOpT  aluOp;
    ccrT    ccrMask;
    execT   exec;

    irdRowDecoder uRowDecoder (
        .clk      (clk),
        .arstN    (arstN),
        .irdValid (irdValid),
        .ird      (ird),
        .decoded  (decoded)
    );

    aluOpSelect uOpSelect (
        .row     (decoded.row),
        .column  (step.column),
        .finish  (step.finish),
        .aluOp   (aluOp),
        .ccrMask (ccrMask)
    );

    aluExecute uExecute (
        .step  (step),
        .row   (decoded.row),
        .aluOp (aluOp),
        .ccrIn (ccr),
        .exec  (exec)
    );

    ccrUpdate uCcrUpdate (
        .clk          (clk),
        .arstN        (arstN),
        .stepValid    (stepValid),
        .exec         (exec),
        .ccrMask      (ccrMask),
        .decoded      (decoded),
        .finish       (step.finish),
        .ccrLoad      (ccrLoad),
        .ccrLoadValue (ccrLoadValue),
        .result       (result),
        .resultValid  (resultValid),
        .ccr          (ccr)
    );

endmodule

// File: testbench/tbAluRef.svh
// Reference model: opcode to row, operation and mask tables, expected result, flags and CCR merge
`ifndef TB_ALU_REF_SVH
`define TB_ALU_REF_SVH

function automatic int rowForOpcode(input logic [15:0] op);
    int         shiftRows[8] = '{2, 3, 5, 4, 8, 11, 10, 9};  // ASR ASL LSR LSL ROXR ROXL ROR ROL
    logic       sz11;
    logic       rdir;
    logic [2:0] kind;
    sz11 = op[7] & op[6];
    rdir = (op[5:4] == 2'b00);
    kind = {(sz11 ? op[10:9] : op[4:3]), op[8]};
    case (op[15:12])
        4'he:    return shiftRows[kind];
        4'hd:    return (op[8] & ~sz11 & rdir) ? 12 : 2;   // ADDX or ADD
        4'h9:    return (op[8] & ~sz11 & rdir) ? 10 : 5;   // SUBX or SUB
        4'hb:    return (op[8] & ~sz11 & (op[5:3] != 3'b001)) ? 13 : 6;
        4'h8:    return (sz11 | (op[8] & rdir)) ? 0 : 14;
        4'hc:    return (sz11 | (op[8] & rdir)) ? 0 : 4;
        4'h4:    return (op[11:8] == 4'b0110) ? 11 : 0;    // NOT
        default: return 0;
    endcase
endfunction

function automatic logic isStickyZOp(input logic [15:0] op, input int row);
    return (op[15:12] inside {4'h4, 4'h9, 4'hd}) && (row == 10 || row == 12);
endfunction

function automatic logic skipsCcrUpdate(input logic [15:0] op);
    return ((op[15:12] inside {4'h9, 4'hd}) && op[7] && op[6])   // ADDA, SUBA
        || ((op[15:12] == 4'h5) && (op[5:3] == 3'b001));         // Quick to An
endfunction

function automatic aluOpT opForStep(input int row, input int col);
    if (col == 1) return opAnd;
    if (col < 2 || col > 4) return opNop;
    case (row)
        2:       return (col == 2) ? opAdd : (col == 3) ? opAddc : opAsr;
        3:       return (col == 4) ? opAsl : opNop;
        4:       return (col == 4) ? opLsl : opAnd;
        5, 6:    return (col == 2) ? opSub : (col == 3) ? opSubc : opLsr;
        8:       return (col == 2) ? opExt : (col == 3) ? opAnd : opRoxr;
        9:       return (col == 4) ? opRol : opNop;
        10:      return (col == 2) ? opSubx : (col == 3) ? opSubc : opRor;
        11:      return (col == 4) ? opRoxl : opSub0;
        12:      return opAddx;
        13:      return opEor;
        14:      return (col == 4) ? opEor : opOr;
        15:      return (col == 3) ? opAdd : opOr;
        default: return opNop;
    endcase
endfunction

function automatic ccrT maskForStep(input int row, input int col, input logic fin);
    if (col == 1) return (fin || row == 13 || row == 14) ? KKZKK : KNZ00;
    if (col == 2 || col == 3) begin
        if (row inside {2, 5, 10, 12}) return CUPDALL;
        if (row inside {6, 11}) return KNZVC;
        if (row inside {4, 8, 13, 14}) return KNZ00;
        return NOMASK;
    end
    if (col == 4) begin
        if (row inside {2, 3, 4, 5, 8, 11}) return CUPDALL;
        if (row inside {9, 10}) return KNZ00;
    end
    return NOMASK;
endfunction

function automatic execT predictExec(input aluOpT op, input int row, input stepT st,
                                     input ccrT cin);
    int          w;
    logic [15:0] m, a, d, res;
    logic [16:0] full;
    logic        c, top, bitIn, ovf, isSub;
    ccrT         f;
    w     = st.isByte ? 8 : 16;
    m     = st.isByte ? 16'h00ff : 16'hffff;
    a     = st.aOperand & m;
    d     = st.dOperand & m;
    top   = a[w-1];
    f     = cin & 5'b10000;   // X kept unless the op sets it
    res   = st.aOperand;
    isSub = op inside {opSub, opSubc, opSubx, opSub0};
    case (op)
        opOr:  res = st.aOperand | st.dOperand;
        opEor: res = st.aOperand ^ st.dOperand;
        opAnd: begin
            res = st.aOperand & st.dOperand;
            if (st.column == 3'd1 && (row == 8 || row == 11)) f[0] = cin[4];
        end
        opAdd, opAddc, opAddx, opSub, opSubc, opSubx, opSub0: begin
            c = (op == opSub0) ? 1'b1 : (op inside {opAddc, opSubc}) ? cin[0]
              : (op inside {opAddx, opSubx}) ? cin[4] : 1'b0;
            full = isSub ? d - a - c : d + a + c;
            res  = full[15:0] & m;
            ovf  = ((d[w-1] ^ a[w-1]) == isSub) && (res[w-1] != d[w-1]);
            if (op != opSub0) begin
                f[0] = full[w];
                f[4] = full[w];
                f[1] = ovf;
            end
            if (st.isByte) res = {{8{res[7]}}, res[7:0]};
        end
        opAsl, opLsl, opRol, opRoxl: begin
            bitIn = (op == opRol) ? top : (op == opRoxl) ? cin[4] : 1'b0;
            res   = ((a << 1) | 16'(bitIn)) & m;
            f[0]  = top;
            if (op != opRol) f[4] = top;
            if (op == opAsl) f[1] = cin[1] | (top ^ a[w-2]);
        end
        opAsr, opLsr, opRor, opRoxr: begin
            bitIn = (op == opAsr) ? top : (op == opRor) ? a[0] : (op == opRoxr) ? cin[4] : 1'b0;
            res   = (a >> 1) | (16'(bitIn) << (w - 1));
            f[0]  = a[0];
            if (op != opRor) f[4] = a[0];
        end
        default: res = st.aOperand;
    endcase
    f[3] = res[w-1];
    f[2] = ((res & m) == 16'h0000);
    return '{result: res, flags: f};
endfunction

// Byte shifts only define the low byte
function automatic wordT definedBits(input aluOpT op, input logic isByte);
    return (isByte && op inside {opAsl, opAsr, opLsl, opLsr, opRol, opRor, opRoxl, opRoxr})
        ? 16'h00ff : 16'hffff;
endfunction

function automatic ccrT mergeFlags(input ccrT old, input ccrT nf, input ccrT mask,
                                   input logic sticky);
    ccrT m;
    m = (nf & mask) | (old & ~mask);
    if (sticky && mask[2]) m[2] = nf[2] & old[2];
    return m;
endfunction

`endif

// File: testbench/tbAluTop.sv
// Testbench for aluTop: clock, reset, directed and random steps, result and CCR checks, timeout
`timescale 1ns/1ps

module tbAluTop;
    import aluPkg::*;
    import decodePkg::*;

    `include "tbAluRef.svh"

    localparam int arithSteps = 6 * 16 + 2;
    localparam int logicSteps = 4 * 16;
    localparam int shiftSteps = 8 * 2 * 6;
    localparam int otherSteps = 4 + 12 + 2;   // ADDA, column 1, load
    localparam int maxCycles  = 2 * (arithSteps + logicSteps + shiftSteps + otherSteps) + 100;

    logic clk, arstN, irdValid, stepValid, ccrLoad, resultValid, stepSeen;
    irdT  ird;
    stepT step;
    ccrT  ccrLoadValue, ccr, modelCcr;
    wordT result, lastResult;
    wordT expResultQ[$], expMaskQ[$];
    ccrT  expCcrQ[$];
    int   curRow, errors, checks, testErrors, cycleCount;
    logic curArX, curNoCcr;
    int   seed = 84;

    aluTop DUT (.clk(clk), .arstN(arstN), .irdValid(irdValid), .ird(ird),
        .stepValid(stepValid), .step(step), .ccrLoad(ccrLoad), .ccrLoadValue(ccrLoadValue),
        .result(result), .resultValid(resultValid), .ccr(ccr));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: run did not finish within %0d cycles", maxCycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) stepSeen <= 1'b0;
        else        stepSeen <= stepValid;   // Step taken at this edge
    end

    // Compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        wordT expRes, expMask;
        ccrT  expCcr;
        if (arstN) begin
            checks++;
            assert (resultValid == stepSeen) else begin
                $display("error at %0t: resultValid expected %b got %b", $time,
                         stepSeen, resultValid);
                errors++;
            end
            if (resultValid) begin
                checks++;
                assert (expResultQ.size() != 0) else begin
                    $display("resultValid came at %0t without a pending step", $time);
                    errors++;
                end
            end
            if (resultValid && expResultQ.size() != 0) begin
                expRes  = expResultQ.pop_front();
                expMask = expMaskQ.pop_front();
                expCcr  = expCcrQ.pop_front();
                checks += 2;
                assert ((result & expMask) == (expRes & expMask)) else begin
                    $display("error at %0t: result expected %h got %h", $time,
                             expRes & expMask, result & expMask);
                    errors++;
                end
                assert (ccr == expCcr) else begin
                    $display("error at %0t: ccr expected %b got %b", $time, expCcr, ccr);
                    errors++;
                end
            end
        end
    end

    task automatic loadIrd(input irdT op);
        stepValid = 1'b0;
        ird       = op;
        irdValid  = 1'b1;
        curRow    = rowForOpcode(op);
        curArX    = isStickyZOp(op, curRow);
        curNoCcr  = skipsCcrUpdate(op);
        @(negedge clk);
        irdValid = 1'b0;
        @(negedge clk);                       // Gap before the first step
    endtask

    task automatic loadCcr(input ccrT val);
        stepValid    = 1'b0;
        ccrLoad      = 1'b1;
        ccrLoadValue = val;
        @(negedge clk);
        ccrLoad  = 1'b0;
        modelCcr = val;
        checks++;
        assert (ccr == val) else begin
            $display("error at %0t: ccr expected %b got %b", $time, val, ccr);
            errors++;
        end
    endtask

    task automatic runStep(input int col, input wordT a, input wordT d, input logic isByte,
                           input logic fin, input logic withLoad, input ccrT loadVal);
        stepT  st;
        aluOpT op;
        execT  ex;
        ccrT   nextCcr;
        st = '{column: col[2:0], aOperand: a, dOperand: d, isByte: isByte, finish: fin};
        op = opForStep(curRow, col);
        ex = predictExec(op, curRow, st, modelCcr);
        nextCcr = curNoCcr ? modelCcr
                : mergeFlags(modelCcr, ex.flags, maskForStep(curRow, col, fin), fin | curArX);
        if (withLoad) nextCcr = loadVal;
        expResultQ.push_back(ex.result);
        expMaskQ.push_back(definedBits(op, isByte));
        expCcrQ.push_back(nextCcr);
        modelCcr     = nextCcr;
        lastResult   = ex.result;
        step         = st;
        stepValid    = 1'b1;
        ccrLoad      = withLoad;
        ccrLoadValue = loadVal;
        @(negedge clk);
        stepValid = 1'b0;
        ccrLoad   = 1'b0;
    endtask

    task automatic drain();
        while (expResultQ.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    // Random steps on word and byte operands for one opcode
    task automatic randomGroup(input irdT op, input int col, input logic zeroSrc, input int n);
        wordT d;
        loadIrd(op);
        loadCcr(ccrT'($random(seed)));
        for (int i = 0; i < 2 * n; i++) begin
            d = zeroSrc ? 16'h0000 : wordT'($random(seed));
            runStep(col, wordT'($random(seed)), d, i[0], 1'b0, 1'b0, '0);
        end
        drain();
    endtask

    task automatic endTest(input string name);
        $display("test %-10s %s, %0d errors", name, (errors == testErrors) ? "ok" : "failed",
                 errors - testErrors);
        testErrors = errors;
    endtask

    initial begin
        irdT  op;
        wordT a;
        ccrT  val;
        logic [2:0] k3;
        arstN        = 1'b0;
        irdValid     = 1'b0;
        ird          = '0;
        stepValid    = 1'b0;
        step         = '0;
        ccrLoad      = 1'b0;
        ccrLoadValue = '0;
        modelCcr     = '0;
        curRow       = 0;
        curArX       = 1'b0;
        curNoCcr     = 1'b0;
        errors       = 0;
        checks       = 0;
        testErrors   = 0;
        cycleCount   = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checks++;
        assert (ccr == '0 && result == '0 && !resultValid) else begin
            $display("outputs are not cleared after reset");
            errors++;
        end
        endTest("reset");

        randomGroup(16'hd040, 2, 1'b0, 8);   // ADD.W
        randomGroup(16'hd040, 3, 1'b0, 8);   // ADD with carry column
        randomGroup(16'h9040, 2, 1'b0, 8);   // SUB
        randomGroup(16'hd140, 2, 1'b0, 8);   // ADDX
        randomGroup(16'h9140, 2, 1'b0, 8);   // SUBX
        randomGroup(16'hb040, 2, 1'b0, 8);   // CMP
        loadIrd(16'hd140);
        loadCcr(5'b00100);
        runStep(2, 16'h0001, 16'h0001, 1'b0, 1'b0, 1'b0, '0);
        runStep(2, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, '0);
        drain();
        checks++;
        assert (ccr[flagZ] == 1'b0) else begin
            $display("error at %0t: ccr.Z expected 0 got %b", $time, ccr[flagZ]);
            errors++;
        end
        endTest("arith");

        randomGroup(16'h8040, 2, 1'b0, 8);   // OR
        randomGroup(16'hb140, 2, 1'b0, 8);   // EOR
        randomGroup(16'hc040, 2, 1'b0, 8);   // AND
        randomGroup(16'h4640, 2, 1'b1, 8);   // NOT
        endTest("logic");

        for (int k = 0; k < 8; k++) begin
            k3 = k[2:0];
            op = 16'he040 | {7'b0, k3[0], 3'b0, k3[2:1], 3'b0};
            loadIrd(op);
            for (int sz = 0; sz < 2; sz++) begin
                loadCcr(ccrT'($random(seed)));
                a = wordT'($random(seed));
                repeat (6) begin
                    runStep(4, a, wordT'($random(seed)), sz[0], 1'b0, 1'b0, '0);
                    a = lastResult;           // Chain through X and C
                end
            end
            drain();
        end
        endTest("shift");

        loadIrd(16'hd0c0);
        val = ccrT'($random(seed));
        loadCcr(val);
        repeat (4) runStep(2, wordT'($random(seed)), wordT'($random(seed)), 1'b0, 1'b0, 1'b0, '0);
        drain();
        checks++;
        assert (ccr == val) else begin
            $display("error at %0t: ccr expected %b got %b", $time, val, ccr);
            errors++;
        end
        endTest("adda");

        randomGroup(16'hb140, 1, 1'b0, 2);   // KKZKK on EOR row
        loadIrd(16'hd040);
        loadCcr(ccrT'($random(seed)));
        repeat (4) runStep(1, wordT'($random(seed)), wordT'($random(seed)), 1'b0, 1'b1, 1'b0, '0);
        drain();
        randomGroup(16'he050, 1, 1'b0, 2);   // ROXR row copies X to C
        endTest("column1");

        repeat (3) loadCcr(ccrT'($random(seed)));
        loadIrd(16'hd040);
        runStep(2, 16'h7fff, 16'h0001, 1'b0, 1'b0, 1'b1, 5'b10101);
        runStep(2, 16'h1234, 16'h4321, 1'b0, 1'b0, 1'b0, '0);
        drain();
        endTest("load");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
common/aluPkg.sv
common/decodePkg.sv
execute/aluShifter.sv
execute/aluExecute.sv
decode/irdRowDecoder.sv
decode/aluOpSelect.sv
src/ccrUpdate.sv
src/aluTop.sv
+incdir+testbench
testbench/tbAluTop.sv
